// ==== Makefile ====
# Verilator build and run of the arithmetic request unit testbench
TOP = alu_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
verilog/alu_pkg.sv
verilog/sync_fifo.sv
verilog/req_arbiter.sv
verilog/op_decode.sv
verilog/alu_execute.sv
verilog/result_queue.sv
verilog/alu_top.sv
sim/alu_properties.sv
sim/alu_tb.sv

// ==== sim/alu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_properties import alu_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    res_write,
  input logic    rq_full,
  input logic    out_valid,
  input logic    out_stall,
  input logic    credit_ret,
  input result_s out_res
);

  // set for good once the matching assertion fails
  logic bad_write  = 1'b0;
  logic bad_hold   = 1'b0;
  logic bad_credit = 1'b0;
  int   held;  // results written and not yet read

  always_ff @(posedge clk or posedge rst) begin
    if (rst) held <= 0;
    else held <= held + int'(res_write) - int'(credit_ret);
  end

  // credits should make this impossible
  no_write_full: assert property (@(posedge clk) disable iff (rst) !(res_write && rq_full))
    else begin
      bad_write = 1'b1;
      $error("result written while the result queue is full");
    end

  hold_stalled: assert property (@(posedge clk) disable iff (rst)
                                 (out_valid && out_stall) |=> $stable(out_res))
    else begin
      bad_hold = 1'b1;
      $error("out_res changed while the consumer stalled");
    end

  credit_needs_result: assert property (@(posedge clk) disable iff (rst)
                                        credit_ret |-> held > 0)
    else begin
      bad_credit = 1'b1;
      $error("credit returned with no result held in the queue");
    end

endmodule

bind result_queue alu_properties u_props (
  .clk, .rst, .res_write, .rq_full, .out_valid, .out_stall, .credit_ret, .out_res
);

`default_nettype wire

// ==== sim/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*;;

  typedef struct packed {
    logic    src;
    cmd_u    cmd;
    result_s exp;
  } vec_s;

  logic       clk = 1'b0;
  logic       rst;
  logic       valid0;
  logic       valid1;
  cmd_u       cmd0;
  cmd_u       cmd1;
  logic [1:0] in_valid;
  cmd_u [1:0] in_cmd;
  logic [1:0] in_stall;
  logic       out_valid;
  result_s    out_res;
  logic       out_stall;

  vec_s        tbl[$];
  string       tbl_name[$];
  int          list0[$];   // table rows per client, in send order
  int          list1[$];
  logic [31:0] lfsr = 32'h8802bc00;
  int          rcv0 = 0;
  int          rcv1 = 0;
  int          rcv_total = 0;
  logic        saw_both_stall = 1'b0;

  assign in_valid  = {valid1, valid0};
  assign in_cmd[0] = cmd0;
  assign in_cmd[1] = cmd1;

  alu_top dut (
    .clk, .rst, .in_valid, .in_cmd, .in_stall, .out_valid, .out_res, .out_stall
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_now($sformatf("Fail %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[6:0], lfsr[0]};
    end
    return r;
  endfunction

  // expected result straight from the opcode rules
  function automatic result_s expect_of(input logic s, input op_e op,
                                        input logic [7:0] x, input logic [7:0] y,
                                        input logic [7:0] z);
    result_s r;
    r.src   = s;
    r.op    = op;
    r.value = 8'h00;
    r.flags = 3'b000;
    case (op)
      op_add: r.value = 8'((int'(x) + int'(y)) % 256);
      op_sub: r.value = 8'((int'(x) - int'(y) + 256) % 256);
      op_cmp: r.flags = {x == y, x > y, x < y};
      op_range: r.flags = {(y <= x) && (x <= z), 2'b00};
      default: ;
    endcase
    if (op == op_add || op == op_sub) r.flags = {r.value == 8'h00, r.value[7], 1'b0};
    return r;
  endfunction

  task automatic add_entry(input string name, input logic s, input op_e op,
                           input logic [7:0] x, input logic [7:0] y, input logic [7:0] z);
    vec_s v;
    v.src = s;
    if (op == op_range) begin
      v.cmd.rng.op   = op;
      v.cmd.rng.val  = x;
      v.cmd.rng.low  = y;
      v.cmd.rng.high = z;
    end else begin
      v.cmd.arith.op     = op;
      v.cmd.arith.a      = x;
      v.cmd.arith.b      = y;
      v.cmd.arith.unused = z;  // junk here must not matter
    end
    v.exp = expect_of(s, op, x, y, z);
    tbl.push_back(v);
    tbl_name.push_back(name);
    if (s) list1.push_back(tbl.size() - 1);
    else list0.push_back(tbl.size() - 1);
  endtask

  task automatic build_table();
    logic [7:0] o;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] z;
    add_entry("add basic",    1'b0, op_add,   8'd12,  8'd30,  8'h5a);
    add_entry("add wrap",     1'b1, op_add,   8'd200, 8'd100, 8'hff);
    add_entry("add to zero",  1'b0, op_add,   8'd128, 8'd128, 8'h00);
    add_entry("add negative", 1'b1, op_add,   8'd100, 8'd50,  8'h3c);
    add_entry("sub basic",    1'b0, op_sub,   8'd50,  8'd20,  8'h00);
    add_entry("sub zero",     1'b1, op_sub,   8'd77,  8'd77,  8'ha5);
    add_entry("sub wrap",     1'b0, op_sub,   8'd5,   8'd10,  8'h00);
    add_entry("cmp equal",    1'b1, op_cmp,   8'd9,   8'd9,   8'h00);
    add_entry("cmp a bigger", 1'b0, op_cmp,   8'd200, 8'd3,   8'h00);
    add_entry("cmp b bigger", 1'b1, op_cmp,   8'd3,   8'd200, 8'h00);
    add_entry("range at low", 1'b0, op_range, 8'd10,  8'd10,  8'd20);
    add_entry("range at high", 1'b1, op_range, 8'd20, 8'd10,  8'd20);
    add_entry("range below",  1'b0, op_range, 8'd9,   8'd10,  8'd20);
    add_entry("range above",  1'b1, op_range, 8'd21,  8'd10,  8'd20);
    for (int k = 0; k < 16; k++) begin
      o = take_bits(2);
      x = take_bits(8);
      y = take_bits(8);
      z = take_bits(8);
      add_entry($sformatf("random %0d", k), k[0], op_e'(o[1:0]), x, y, z);
    end
  endtask

  // one client: hold each word until the arbiter takes it
  task automatic feed_client(input logic c);
    int n;
    int idx;
    int t;
    logic stalled;
    n = c ? list1.size() : list0.size();
    for (int k = 0; k < n; k++) begin
      idx = c ? list1[k] : list0[k];
      @(negedge clk);
      if (c) begin
        valid1 = 1'b1;
        cmd1   = tbl[idx].cmd;
      end else begin
        valid0 = 1'b1;
        cmd0   = tbl[idx].cmd;
      end
      t = 0;
      stalled = 1'b1;
      while (stalled) begin
        @(posedge clk);
        stalled = in_stall[c];
        t++;
        if (stalled && t > 500) begin
          fail_now($sformatf("client %0d request %s was never accepted", c, tbl_name[idx]));
        end
      end
    end
    @(negedge clk);
    if (c) valid1 = 1'b0;
    else valid0 = 1'b0;
  endtask

  // full stall at first so the queues fill, random after that
  task automatic drive_stall();
    int cyc;
    logic [7:0] sb;
    cyc = 0;
    while (rcv_total < tbl.size()) begin
      @(negedge clk);
      sb = take_bits(1);
      out_stall = (cyc < 40) ? 1'b1 : sb[0];
      cyc++;
      if (cyc > 5000) fail_now("results stopped arriving before every request was answered");
    end
  endtask

  always @(posedge clk) begin
    if (!rst && in_stall == 2'b11) saw_both_stall = 1'b1;
    if (!rst && out_valid && !out_stall) begin
      if (out_res.src == 1'b0) begin
        if (rcv0 >= list0.size()) fail_now("client 0 got a result it never asked for");
        check(tbl_name[list0[rcv0]], 32'(tbl[list0[rcv0]].exp), 32'(out_res));
        rcv0++;
      end else begin
        if (rcv1 >= list1.size()) fail_now("client 1 got a result it never asked for");
        check(tbl_name[list1[rcv1]], 32'(tbl[list1[rcv1]].exp), 32'(out_res));
        rcv1++;
      end
      rcv_total++;
    end
  end

  initial begin
    rst       = 1'b1;
    valid0    = 1'b0;
    valid1    = 1'b0;
    cmd0      = '0;
    cmd1      = '0;
    out_stall = 1'b1;
    build_table();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("reset out_valid", 32'd0, 32'(out_valid));
    check("reset in_stall", 32'd0, 32'(in_stall));
    fork
      feed_client(1'b0);
      feed_client(1'b1);
      drive_stall();
    join
    out_stall = 1'b0;
    repeat (20) @(negedge clk);  // leaves room for a stray extra result
    check("client 0 result count", 32'(list0.size()), 32'(rcv0));
    check("client 1 result count", 32'(list1.size()), 32'(rcv1));
    check("both clients stalled", 32'd1, 32'(saw_both_stall));
    if (!(dut.u_rq.u_props.bad_write | dut.u_rq.u_props.bad_hold |
          dut.u_rq.u_props.bad_credit)) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_now("an assertion on the result queue failed");
    end
  end

endmodule

`default_nettype wire

// ==== verilog/alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_execute import alu_pkg::*; #(
  parameter int exec_lat = 3,
  parameter int rq_depth = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    dec_valid,
  input  exec_s   dec_op,
  output logic    dec_take,
  input  logic    credit_ret,
  output logic    res_write,
  output result_s res
);

  localparam int cw = $clog2(rq_depth + 1);

  logic [cw-1:0]          credits;   // free result queue slots
  logic [d_w-1:0]         sum;
  result_s                calc;
  logic [exec_lat-1:0]    vld_pipe;
  result_s [exec_lat-1:0] res_pipe;

  assign dec_take = dec_valid & (credits != '0);

  // add and sub wrap at d_w bits
  assign sum = (dec_op.op == op_sub) ? dec_op.a - dec_op.b : dec_op.a + dec_op.b;

  always_comb begin
    calc.src   = dec_op.src;
    calc.op    = dec_op.op;
    calc.value = '0;
    calc.flags = '0;
    case (dec_op.op)
      op_add, op_sub: begin
        calc.value = sum;
        calc.flags = {sum == '0, sum[d_w-1], 1'b0};
      end
      op_cmp:   calc.flags = {dec_op.a == dec_op.b, dec_op.a > dec_op.b, dec_op.b > dec_op.a};
      op_range: calc.flags = {(dec_op.a >= dec_op.b) && (dec_op.a <= dec_op.c), 2'b00};
      default:  ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credits  <= cw'(rq_depth);
      vld_pipe <= '0;
    end else begin
      case ({dec_take, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;  // take and return cancel
      endcase
      vld_pipe <= {vld_pipe[exec_lat-2:0], dec_take};
    end
  end

  // data shifts every cycle, the valid bit marks real items
  always_ff @(posedge clk) begin
    res_pipe <= {res_pipe[exec_lat-2:0], calc};
  end

  assign res_write = vld_pipe[exec_lat-1];
  assign res       = res_pipe[exec_lat-1];

endmodule

`default_nettype wire

// ==== verilog/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

  localparam int d_w = 8;  // operand width

  typedef enum logic [1:0] {
    op_add   = 2'd0,
    op_sub   = 2'd1,
    op_cmp   = 2'd2,
    op_range = 2'd3
  } op_e;

  // arithmetic view: two operands, low byte spare
  typedef struct packed {
    op_e            op;
    logic [d_w-1:0] a;
    logic [d_w-1:0] b;
    logic [7:0]     unused;
  } arith_cmd_s;

  // range view: value checked against low..high
  typedef struct packed {
    op_e            op;
    logic [d_w-1:0] val;
    logic [d_w-1:0] low;
    logic [d_w-1:0] high;
  } range_cmd_s;

  // op sits at the top in both views
  typedef union packed {
    arith_cmd_s arith;
    range_cmd_s rng;
  } cmd_u;

  typedef struct packed {
    logic src;  // client index
    cmd_u cmd;
  } req_s;

  typedef struct packed {
    logic           src;
    op_e            op;
    logic [d_w-1:0] a;  // value for range
    logic [d_w-1:0] b;  // low for range
    logic [d_w-1:0] c;  // high for range, zero otherwise
  } exec_s;

  typedef struct packed {
    logic           src;
    op_e            op;
    logic [d_w-1:0] value;
    logic [2:0]     flags;  // {zero,neg,0} / {eq,a_gt,b_gt} / {in_range,0,0}
  } result_s;

endpackage

`default_nettype wire

// ==== verilog/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; #(
  parameter int arb_depth = 4,
  parameter int exec_lat  = 3,
  parameter int rq_depth  = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] in_valid,
  input  cmd_u [1:0] in_cmd,
  output logic [1:0] in_stall,
  output logic       out_valid,
  output result_s    out_res,
  input  logic       out_stall
);

  logic    q_pop;
  logic    q_empty;
  req_s    q_head;
  logic    dec_valid;
  logic    dec_take;
  exec_s   dec_op;
  logic    res_write;
  logic    credit_ret;
  result_s res;

  req_arbiter #(.arb_depth(arb_depth)) u_arb (
    .clk, .rst, .in_valid, .in_cmd, .in_stall, .q_pop, .q_head, .q_empty
  );

  op_decode u_dec (
    .clk, .rst, .q_head, .q_empty, .q_pop, .dec_valid, .dec_op, .dec_take
  );

  alu_execute #(.exec_lat(exec_lat), .rq_depth(rq_depth)) u_exec (
    .clk, .rst, .dec_valid, .dec_op, .dec_take, .credit_ret, .res_write, .res
  );

  result_queue #(.rq_depth(rq_depth)) u_rq (
    .clk, .rst, .res_write, .res, .credit_ret, .out_valid, .out_res, .out_stall
  );

endmodule

`default_nettype wire

// ==== verilog/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decode import alu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  req_s  q_head,
  input  logic  q_empty,
  output logic  q_pop,
  output logic  dec_valid,
  output exec_s dec_op,
  input  logic  dec_take
);

  exec_s nxt_op;

  // a and b share their bits with val and low, only c depends on the view
  always_comb begin
    nxt_op.src = q_head.src;
    nxt_op.op  = q_head.cmd.arith.op;  // same bits in either view
    nxt_op.a   = q_head.cmd.arith.a;   // val in the range view
    nxt_op.b   = q_head.cmd.arith.b;   // low in the range view
    if (q_head.cmd.arith.op == op_range) begin
      nxt_op.c = q_head.cmd.rng.high;
    end else begin
      nxt_op.c = '0;  // spare byte ignored
    end
  end

  // refill when empty or when execute takes the current item
  assign q_pop = ~q_empty & (~dec_valid | dec_take);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (q_pop) begin
      dec_valid <= 1'b1;
    end else if (dec_take) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) dec_op <= nxt_op;
  end

endmodule

`default_nettype wire

// ==== verilog/req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import alu_pkg::*; #(
  parameter int arb_depth = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] in_valid,
  input  cmd_u [1:0] in_cmd,
  output logic [1:0] in_stall,
  input  logic       q_pop,
  output req_s       q_head,
  output logic       q_empty
);

  logic       rr;       // client with first choice
  logic       q_full;
  logic       gnt_any;
  logic       gnt_src;
  logic [1:0] gnt;
  req_s       wr_req;

  // pointer client wins if valid, else the other one
  assign gnt_src = in_valid[rr] ? rr : ~rr;
  assign gnt_any = ~q_full & (|in_valid);
  assign gnt     = gnt_any ? (2'b01 << gnt_src) : 2'b00;

  // valid but not granted means stalled, client holds its word
  assign in_stall = in_valid & ~gnt;

  assign wr_req.src = gnt_src;
  assign wr_req.cmd = in_cmd[gnt_src];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rr <= 1'b0;
    end else if (gnt_any) begin
      rr <= ~gnt_src;  // other client gets first pick next time
    end
  end

  sync_fifo #(
    .width($bits(req_s)),
    .depth(arb_depth)
  ) u_req_q (
    .clk,
    .rst,
    .wr    (gnt_any),
    .rd    (q_pop),
    .din   (wr_req),
    .dout  (q_head),
    .full  (q_full),
    .empty (q_empty)
  );

endmodule

`default_nettype wire

// ==== verilog/result_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_queue import alu_pkg::*; #(
  parameter int rq_depth = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    res_write,
  input  result_s res,
  output logic    credit_ret,
  output logic    out_valid,
  output result_s out_res,
  input  logic    out_stall
);

  logic rq_full;
  logic rq_empty;
  logic rq_wr;

  // credits upstream keep this from ever dropping a result
  assign rq_wr = res_write & ~rq_full;

  assign out_valid = ~rq_empty;

  // one credit back per result the consumer takes
  assign credit_ret = out_valid & ~out_stall;

  sync_fifo #(
    .width($bits(result_s)),
    .depth(rq_depth)
  ) u_res_q (
    .clk,
    .rst,
    .wr    (rq_wr),
    .rd    (credit_ret),
    .din   (res),
    .dout  (out_res),
    .full  (rq_full),
    .empty (rq_empty)
  );

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr,
  input  logic             rd,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    rd_ptr;
  logic [aw-1:0]    wr_ptr;
  logic [cw-1:0]    count;  // occupancy
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr & ~full;   // write while full is dropped
  assign do_rd = rd & ~empty;
  assign full  = (count == cw'(depth));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];  // head always visible

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= din;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither leave count alone
      endcase
    end
  end

endmodule

`default_nettype wire
